// ==== Makefile ====
# Verilator build and run for the execCore testbench

VERILATOR  ?= verilator
TOP        := execCore_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
LOG        := sim.log
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only if the pass message stands on a line of its own
run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/execCore_checker.sv ====
/*
  Concurrent checks on the execCore output pulses and write enable.
  Assumes the fixed one-cycle latency of OUT and illegal-opcode pulses.
  Expects execCore to carry its write-back bundle on a signal named regWrite.
*/
`timescale 1ns/10ps

module execCore_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    instrValid,
	input isa_pkg::instr_t         instr,
	input logic                    outValid,
	input logic                    illegalInstr,
	input datapath_pkg::regWrite_t regWrite
);

	int failCount = 0;

	logic [3:0] opcode;
	logic       outReq;
	logic       illegalReq;

	// accepted requests, as seen at the sampling edge
	assign opcode     = instr.opcode;
	assign outReq     = rst_n && instrValid && (opcode == 4'd9);
	assign illegalReq = rst_n && instrValid && (opcode >= 4'd10);

	// synchronous reset clears both pulses
	resetClearsPulses: assert property (@(posedge clk) !rst_n |=> !outValid && !illegalInstr)
	else begin
		failCount++;
		$error("outValid or illegalInstr high after a reset cycle");
	end

	// OUT gives a pulse one cycle later
	outPulseFollows: assert property (@(posedge clk) outReq |=> outValid)
	else begin
		failCount++;
		$error("outValid missing one cycle after an OUT");
	end

	// and never without one
	noStrayOut: assert property (@(posedge clk) !outReq |=> !outValid)
	else begin
		failCount++;
		$error("outValid high without a preceding OUT");
	end

	illegalPulseFollows: assert property (@(posedge clk) illegalReq |=> illegalInstr)
	else begin
		failCount++;
		$error("illegalInstr missing one cycle after an undefined opcode");
	end

	noStrayIllegal: assert property (@(posedge clk) !illegalReq |=> !illegalInstr)
	else begin
		failCount++;
		$error("illegalInstr high without a preceding undefined opcode");
	end

	// idle cycles and undefined opcodes leave the register file alone
	noWriteWhenIdle: assert property (@(posedge clk) !instrValid || illegalReq |-> !regWrite.writeEn)
	else begin
		failCount++;
		$error("register write enabled with no legal instruction");
	end

endmodule

// attach to every execCore instance
bind execCore execCore_checker i_execCoreChecker (
	.clk          (clk),
	.rst_n        (rst_n),
	.instrValid   (instrValid),
	.instr        (instr),
	.outValid     (outValid),
	.illegalInstr (illegalInstr),
	.regWrite     (regWrite)
);

// ==== bench/execCore_tb.sv ====
/*
  Self-checking testbench for execCore with its own register model.
  Inputs change at the rising edge, outputs are compared at the falling edge.
  Random stimulus is fixed by seed 3; pulse timing is checked by the bound checker.
*/
`timescale 1ns/10ps

module execCore_tb;

	localparam int OUT_TIMEOUT  = 4;
	localparam int RANDOM_COUNT = 400;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                instrValid;
	isa_pkg::instr_t     instr;
	logic                outValid;
	datapath_pkg::word_t outData;
	logic                illegalInstr;

	// reference register model and one-deep output record
	datapath_pkg::word_t model [8];
	logic                expOut;
	logic                expIllegal;
	datapath_pkg::word_t expData;
	logic [3:0]          modelOp;

	integer seed;
	int     errorCount   = 0;
	int     timeoutCount = 0;
	int     outChecks    = 0;
	int     checkerFails;

	execCore i_execCore (
		.clk          (clk),
		.rst_n        (rst_n),
		.instrValid   (instrValid),
		.instr        (instr),
		.outValid     (outValid),
		.outData      (outData),
		.illegalInstr (illegalInstr)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// register-register and OUT encoding, spare bits zero
	function automatic isa_pkg::instr_t encodeReg(input logic [3:0] op, input logic [2:0] rd,
			input logic [2:0] rs1, input logic [2:0] rs2);
		return isa_pkg::instr_t'({op, rd, rs1, rs2, 3'b000});
	endfunction

	function automatic isa_pkg::instr_t encodeLdi(input logic [2:0] rd, input logic [8:0] imm);
		return isa_pkg::instr_t'({4'd8, rd, imm});
	endfunction

	// ISA rules for every writing opcode, LDI falls to default
	function automatic datapath_pkg::word_t expectedResult(input logic [3:0] op,
			input datapath_pkg::word_t a, input datapath_pkg::word_t b, input logic [8:0] imm);
		case (op)
			4'd1: return a + b;
			4'd2: return a - b;
			4'd3: return a & b;
			4'd4: return a | b;
			4'd5: return a ^ b;
			4'd6: return a << b[4:0];
			4'd7: return a >> b[4:0];
			default: return {{23{imm[8]}}, imm};
		endcase
	endfunction

	// model update at the same edge the DUT samples
	always @(posedge clk) begin
		expOut     = 1'b0;
		expIllegal = 1'b0;
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				model[i] = '0;
			end
		end else if (instrValid) begin
			modelOp = instr.opcode;
			if (modelOp == 4'd9) begin
				expOut  = 1'b1;
				expData = model[instr.rs1];
			end else if (modelOp >= 4'd10) begin
				expIllegal = 1'b1;
			end else if (modelOp != 4'd0) begin
				model[instr.rd] = expectedResult(modelOp, model[instr.rs1], model[instr.rs2],
					{instr.rs1, instr.rs2, instr.spare});
			end
		end
	end

	// output comparison mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (outValid === expOut) else begin
				errorCount++;
				$display("Error: outValid expected %h, actual %h", expOut, outValid);
			end
			assert (illegalInstr === expIllegal) else begin
				errorCount++;
				$display("Error: illegalInstr expected %h, actual %h", expIllegal, illegalInstr);
			end
			if (expOut) begin
				outChecks++;
				assert (outData === expData) else begin
					errorCount++;
					$display("Error: outData expected %h, actual %h", expData, outData);
				end
			end
		end
	end

	task automatic sendInstr(input isa_pkg::instr_t word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= word;
	endtask

	// instr keeps its old value, only the strobe drops
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			instrValid <= 1'b0;
		end
	endtask

	task automatic waitOutPulse();
		int  count;
		logic seen;
		count = 0;
		seen  = 1'b0;
		while (!seen && count < OUT_TIMEOUT) begin
			@(negedge clk);
			seen = outValid;
			count++;
		end
		if (!seen) begin
			timeoutCount++;
			$display("Timeout: no outValid pulse within %0d cycles of an OUT", OUT_TIMEOUT);
		end
	endtask

	// read back every register
	task automatic outAll();
		for (int r = 0; r < 8; r++) begin
			sendInstr(encodeReg(4'd9, 3'd0, 3'(r), 3'd0));
		end
		idle(1);
		waitOutPulse();
	endtask

	// biased opcode mix, undefined codes included
	task automatic sendRandom();
		logic [31:0] rnd;
		logic [7:0]  pick;
		logic [3:0]  op;
		rnd  = $random(seed);
		pick = rnd[31:24] % 8'd20;
		if (pick < 8'd10) begin
			op = pick[3:0];
		end else if (pick < 8'd13) begin
			op = 4'd8;
		end else if (pick < 8'd17) begin
			op = 4'd9;
		end else begin
			op = 4'd10 + 4'(rnd[23:21] % 3'd6);
		end
		sendInstr(isa_pkg::instr_t'({op, rnd[11:0]}));
	endtask

	initial begin
		logic [31:0] rnd;
		logic [2:0]  rd;
		logic [2:0]  rs1;
		logic [2:0]  rs2;
		seed       = 3;
		rst_n      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// all zero after reset
		outAll();

		// LDI from both halves, each read back at once
		for (int r = 0; r < 8; r++) begin
			rnd = $random(seed);
			sendInstr(encodeLdi(3'(r), {r[0], rnd[7:0]}));
			sendInstr(encodeReg(4'd9, 3'd0, 3'(r), 3'd0));
		end
		idle(1);
		waitOutPulse();

		// each ALU op, plain and with rd aliasing rs1 or rs2
		for (int op = 1; op < 8; op++) begin
			for (int v = 0; v < 3; v++) begin
				rnd = $random(seed);
				rs1 = rnd[2:0];
				rs2 = rnd[5:3];
				rd  = (v == 0) ? rnd[8:6] : ((v == 1) ? rs1 : rs2);
				sendInstr(encodeReg(4'(op), rd, rs1, rs2));
				sendInstr(encodeReg(4'd9, 3'd0, rd, 3'd0));
			end
		end
		idle(1);
		waitOutPulse();

		// undefined opcodes must not touch any register
		for (int op = 10; op < 16; op++) begin
			rnd = $random(seed);
			sendInstr(isa_pkg::instr_t'({4'(op), rnd[11:0]}));
		end
		idle(2);
		outAll();

		// random mix with idle gaps
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			rnd = $random(seed);
			if (rnd[31:29] == 3'd0) begin
				idle(1);
			end else begin
				sendRandom();
			end
		end
		idle(2);
		outAll();
		idle(2);

		checkerFails = i_execCore.i_execCoreChecker.failCount;
		$display("Summary: %0d outData checks, %0d value errors, %0d timeouts, %0d checker failures",
			outChecks, errorCount, timeoutCount, checkerFails);
		if (errorCount == 0 && timeoutCount == 0 && checkerFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
src/isa_pkg.sv
src/datapath_pkg.sv
src/regFile.sv
src/instrDecoder.sv
src/alu.sv
src/execCore.sv
bench/execCore_checker.sv
bench/execCore_tb.sv

// ==== include/core_params.svh ====
/*
  Core sizing macros shared by packages and RTL.
  Values are fixed; the RTL is only meant to work at these widths.
  REG_SEL_WIDTH must cover REG_COUNT exactly so no select is out of range.
*/
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// register and ALU width
`define DATA_WIDTH 32

// number of architectural registers
`define REG_COUNT 8

// bits needed to address one register
`define REG_SEL_WIDTH 3

// one instruction per strobe
`define INSTR_WIDTH 16

`endif

// ==== src/alu.sv ====
/*
  Single-cycle combinational ALU.
  Add and subtract wrap modulo 2**DATA_WIDTH; overflow is not reported.
  Shifts are logical, by the low bits of the B operand only.
*/
`timescale 1ns/10ps
`include "core_params.svh"

module alu (
	input  datapath_pkg::aluOp_t aluOp,
	input  logic                 useImm,
	input  datapath_pkg::word_t  a,
	input  datapath_pkg::word_t  b,
	input  datapath_pkg::word_t  imm,
	output datapath_pkg::word_t  result
);

	// shift amount width, 5 for a 32-bit word
	localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

	datapath_pkg::word_t      opB;
	logic [SHAMT_WIDTH-1:0]   shamt;

	// B operand: register or sign-extended immediate
	assign opB = useImm ? imm : b;

	// upper bits of B are ignored for shifts
	assign shamt = opB[SHAMT_WIDTH-1:0];

	always_comb begin
		case (aluOp)
			datapath_pkg::ALU_ADD: begin
				result = a + opB;
			end
			datapath_pkg::ALU_SUB: begin
				result = a - opB;
			end
			datapath_pkg::ALU_AND: begin
				result = a & opB;
			end
			datapath_pkg::ALU_OR: begin
				result = a | opB;
			end
			datapath_pkg::ALU_XOR: begin
				result = a ^ opB;
			end
			datapath_pkg::ALU_SHL: begin
				result = a << shamt;
			end
			datapath_pkg::ALU_SHR: begin
				// zero fill from the top
				result = a >> shamt;
			end
			datapath_pkg::ALU_PASSB: begin
				result = opB;
			end
			default: begin
				result = opB;
			end
		endcase
	end

endmodule

// ==== src/datapath_pkg.sv ====
/*
  Datapath types: data word, ALU operation and the write-back bundle.
  regWrite_t is 36 bits wide: enable, destination select, data.
*/
`include "core_params.svh"

package datapath_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;

	// PASSB forwards the B operand, used by LDI
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SHL   = 3'd5,
		ALU_SHR   = 3'd6,
		ALU_PASSB = 3'd7
	} aluOp_t;

	// one register-file write, applied at the clock edge
	typedef struct packed {
		logic            writeEn;
		isa_pkg::regSel_t rd;
		word_t           data;
	} regWrite_t;

endpackage

// ==== src/execCore.sv ====
/*
  Single-cycle execution core, one instruction per valid strobe.
  Register write-back lands at the edge ending the instruction's cycle.
  OUT and illegal-opcode results appear one cycle later, for one cycle.
  No back-pressure: every strobed instruction completes.
*/
`timescale 1ns/10ps

module execCore (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instrValid,
	input  isa_pkg::instr_t     instr,
	output logic                outValid,
	output datapath_pkg::word_t outData,
	output logic                illegalInstr
);

	isa_pkg::regSel_t        rs1Sel;
	isa_pkg::regSel_t        rs2Sel;
	datapath_pkg::aluOp_t    aluOp;
	logic                    useImm;
	datapath_pkg::word_t     immValue;
	datapath_pkg::regWrite_t wbCtl;
	datapath_pkg::regWrite_t regWrite;
	logic                    isOut;
	logic                    isIllegal;
	datapath_pkg::word_t     rs1Data;
	datapath_pkg::word_t     rs2Data;
	datapath_pkg::word_t     aluResult;

	instrDecoder i_instrDecoder (
		.instrValid (instrValid),
		.instr      (instr),
		.rs1Sel     (rs1Sel),
		.rs2Sel     (rs2Sel),
		.aluOp      (aluOp),
		.useImm     (useImm),
		.immValue   (immValue),
		.wbCtl      (wbCtl),
		.isOut      (isOut),
		.isIllegal  (isIllegal)
	);

	// decoder control plus ALU result forms the write
	always_comb begin
		regWrite      = wbCtl;
		regWrite.data = aluResult;
	end

	regFile i_regFile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1Sel   (rs1Sel),
		.rs2Sel   (rs2Sel),
		.regWrite (regWrite),
		.rs1Data  (rs1Data),
		.rs2Data  (rs2Data)
	);

	alu i_alu (
		.aluOp  (aluOp),
		.useImm (useImm),
		.a      (rs1Data),
		.b      (rs2Data),
		.imm    (immValue),
		.result (aluResult)
	);

	// output stage
	// outData holds its last value between OUT instructions
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outValid     <= 1'b0;
			outData      <= '0;
			illegalInstr <= 1'b0;
		end else begin
			outValid     <= isOut;
			illegalInstr <= isIllegal;
			if (isOut) begin
				outData <= rs1Data;
			end
		end
	end

endmodule

// ==== src/instrDecoder.sv ====
/*
  Combinational decoder; the only place opcodes are interpreted.
  All control decisions are forced off while instrValid is low.
  wbCtl carries enable and rd only; the top fills in the data field.
*/
`timescale 1ns/10ps
`include "core_params.svh"

module instrDecoder (
	input  logic                    instrValid,
	input  isa_pkg::instr_t         instr,
	output isa_pkg::regSel_t        rs1Sel,
	output isa_pkg::regSel_t        rs2Sel,
	output datapath_pkg::aluOp_t    aluOp,
	output logic                    useImm,
	output datapath_pkg::word_t     immValue,
	output datapath_pkg::regWrite_t wbCtl,
	output logic                    isOut,
	output logic                    isIllegal
);

	// bits needed to sign-extend the immediate to a full word
	localparam int EXT_WIDTH = `DATA_WIDTH - isa_pkg::IMM_WIDTH;

	isa_pkg::imm_t imm;
	logic          writeEn;

	// register selects are plain field extraction
	assign rs1Sel = instr.rs1;
	assign rs2Sel = instr.rs2;

	// LDI immediate overlays rs1, rs2 and spare
	assign imm      = {instr.rs1, instr.rs2, instr.spare};
	assign immValue = {{EXT_WIDTH{imm[isa_pkg::IMM_WIDTH-1]}}, imm};

	// opcode classification
	always_comb begin
		aluOp     = datapath_pkg::ALU_ADD;
		useImm    = 1'b0;
		writeEn   = 1'b0;
		isOut     = 1'b0;
		isIllegal = 1'b0;
		if (instrValid) begin
			case (instr.opcode)
				isa_pkg::OP_NOP: begin
					// nothing to do
				end
				isa_pkg::OP_ADD: begin
					aluOp   = datapath_pkg::ALU_ADD;
					writeEn = 1'b1;
				end
				isa_pkg::OP_SUB: begin
					aluOp   = datapath_pkg::ALU_SUB;
					writeEn = 1'b1;
				end
				isa_pkg::OP_AND: begin
					aluOp   = datapath_pkg::ALU_AND;
					writeEn = 1'b1;
				end
				isa_pkg::OP_OR: begin
					aluOp   = datapath_pkg::ALU_OR;
					writeEn = 1'b1;
				end
				isa_pkg::OP_XOR: begin
					aluOp   = datapath_pkg::ALU_XOR;
					writeEn = 1'b1;
				end
				isa_pkg::OP_SHL: begin
					aluOp   = datapath_pkg::ALU_SHL;
					writeEn = 1'b1;
				end
				isa_pkg::OP_SHR: begin
					aluOp   = datapath_pkg::ALU_SHR;
					writeEn = 1'b1;
				end
				isa_pkg::OP_LDI: begin
					// immediate goes straight through the ALU
					aluOp   = datapath_pkg::ALU_PASSB;
					useImm  = 1'b1;
					writeEn = 1'b1;
				end
				isa_pkg::OP_OUT: begin
					isOut = 1'b1;
				end
				default: begin
					// codes 10..15, no write
					isIllegal = 1'b1;
				end
			endcase
		end
	end

	// write-back control, data filled in by the top
	always_comb begin
		wbCtl         = '0;
		wbCtl.writeEn = writeEn;
		wbCtl.rd      = instr.rd;
	end

endmodule

// ==== src/isa_pkg.sv ====
/*
  Instruction encoding types for the 16-bit ISA.
  Opcodes 10..15 are undefined and treated as illegal by the decoder.
  For LDI the immediate overlays rs1, rs2 and the spare bits.
*/
`include "core_params.svh"

package isa_pkg;

	// field widths derived from the instruction word
	localparam int OPCODE_WIDTH = 4;
	localparam int SPARE_WIDTH  = `INSTR_WIDTH - OPCODE_WIDTH - 3 * `REG_SEL_WIDTH;
	localparam int IMM_WIDTH    = 2 * `REG_SEL_WIDTH + SPARE_WIDTH;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7,
		OP_LDI = 4'd8,
		OP_OUT = 4'd9
	} opcode_t;

	typedef logic [`REG_SEL_WIDTH-1:0] regSel_t;

	// raw LDI immediate, sign bit on top
	typedef logic [IMM_WIDTH-1:0] imm_t;

	// msb first: opcode, rd, rs1, rs2, spare
	typedef struct packed {
		opcode_t                opcode;
		regSel_t                rd;
		regSel_t                rs1;
		regSel_t                rs2;
		logic [SPARE_WIDTH-1:0] spare;
	} instr_t;

endpackage

// ==== src/regFile.sv ====
/*
  REG_COUNT registers of DATA_WIDTH bits, all cleared by synchronous reset.
  Two combinational read ports, one write port applied at the rising edge.
  A write becomes visible to reads in the following cycle; no bypass.
*/
`timescale 1ns/10ps
`include "core_params.svh"

module regFile (
	input  logic                    clk,
	input  logic                    rst_n,
	input  isa_pkg::regSel_t        rs1Sel,
	input  isa_pkg::regSel_t        rs2Sel,
	input  datapath_pkg::regWrite_t regWrite,
	output datapath_pkg::word_t     rs1Data,
	output datapath_pkg::word_t     rs2Data
);

	// register storage
	datapath_pkg::word_t regs [`REG_COUNT];

	// one-hot write strobe per register
	logic [`REG_COUNT-1:0] wrStrobe;

	// write decoder, gated by the write enable
	always_comb begin
		wrStrobe = '0;
		if (regWrite.writeEn) begin
			wrStrobe[regWrite.rd] = 1'b1;
		end
	end

	// state update
	// reset wins over any pending write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				if (wrStrobe[i]) begin
					regs[i] <= regWrite.data;
				end
			end
		end
	end

	// read port 1
	// select width matches the register count, every index is valid
	always_comb begin
		rs1Data = regs[rs1Sel];
	end

	// read port 2
	always_comb begin
		rs2Data = regs[rs2Sel];
	end

endmodule
